/* test/sched_cases.txt */
# test <ready mode>: 0 keeps every egress ready high, 1 toggles ready at random
# pkt <queue> <byte length>: queue = port * 4 + priority; end closes a test
test 0
pkt 0 100
pkt 1 64
pkt 3 200
pkt 2 130
pkt 3 128
pkt 0 1
pkt 1 65
end
test 0
pkt 4 64
pkt 9 1500
pkt 14 63
pkt 7 1
pkt 13 192
pkt 6 65
pkt 11 128
pkt 2 640
end
test 1
pkt 3 300
pkt 5 257
pkt 10 90
pkt 15 512
pkt 1 64
pkt 7 700
pkt 8 33
pkt 12 129
pkt 6 1000
pkt 13 2
end
test 1
pkt 8 64
pkt 9 65
pkt 10 127
pkt 11 1499
pkt 8 256
pkt 11 5
pkt 0 400
end

/* project.f */
hdl/sched_pkg.sv
hdl/queue_len_store.sv
hdl/port_arbiter.sv
hdl/dequeue_engine.sv
hdl/sched_top.sv
test/sched_tb.sv

/* Makefile */
# Verilator build and run of the scheduler testbench

SOURCES := $(shell cat project.f)

run: obj_dir/Vsched_tb
	./obj_dir/Vsched_tb

obj_dir/Vsched_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module sched_tb -f project.f -o Vsched_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

/* test/sched_tb.sv */
/* Scheduler testbench with clock, reset, stimulus read from the cases file,
   per-port reference model of expected words and note checks */

module sched_tb;

    import sched_pkg::*;

    localparam int num_ports    = 4;
    localparam int data_bytes   = bus_data_bytes;
    localparam int queue_depth  = 16;
    localparam int queue_log    = $clog2(num_ports) + queues_per_port_log;
    localparam int quiet_cycles = 10;

    logic                 core_clk_ifc;
    logic                 rst;
    logic                 enq_valid;
    logic [queue_log-1:0] enq_queue;
    blen_t                enq_blen;
    logic [num_ports-1:0] egr_ready;
    logic                 note_valid;
    logic [queue_log-1:0] note_queue;
    blen_t                note_bytes;
    logic                 note_last;

    // Tests and packets from the cases file
    int test_mode[$];
    int test_first[$];
    int test_size[$];
    int pkt_queue[$];
    int pkt_blen[$];

    // Expected words, packed as port, queue, last and bytes
    int exp_words[$];

    int                   seed = 92;
    int                   limit_cycles = 0;
    logic                 load_phase = 1'b1;
    logic [num_ports-1:0] ready_now;
    int                   low_run [num_ports];
    logic                 pkt_open [num_ports];
    int                   open_queue [num_ports];

    sched_top #(
        .NUM_PORTS   (num_ports),
        .DATA_BYTES  (data_bytes),
        .QUEUE_DEPTH (queue_depth)
    ) uut (
        .clk         (core_clk_ifc),
        .rst         (rst),
        .enq_valid   (enq_valid),
        .enq_queue   (enq_queue),
        .enq_blen    (enq_blen),
        .egr_ready   (egr_ready),
        .note_valid  (note_valid),
        .note_queue  (note_queue),
        .note_bytes  (note_bytes),
        .note_last   (note_last)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever begin
            #10 core_clk_ifc = ~core_clk_ifc;
        end
    end

    //////////////////////////////////////////////////
    // Failure reporting and the value check

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] time %0t: %s expected %0d, got %0d", $time, name,
                     expected, actual);
            report_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model

    function automatic int packet_words(input int blen);
        return (blen + data_bytes - 1) / data_bytes;
    endfunction

    function automatic int pack_word(input int port, input int queue, input int last,
                                     input int bytes);
        return (port << 24) | (queue << 16) | (last << 12) | bytes;
    endfunction

    task automatic read_cases();
        int    fd;
        int    code;
        int    q;
        int    len;
        int    mode;
        int    last_test;
        string tok;
        string rest;
        fd = $fopen("test/sched_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file test/sched_cases.txt");
            report_failure();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%d", mode);
                test_mode.push_back(mode);
                test_first.push_back(pkt_queue.size());
                test_size.push_back(0);
            end else if (tok == "pkt") begin
                code = $fscanf(fd, "%d %d", q, len);
                if (code != 2 || test_size.size() == 0) begin
                    $display("A packet line in the cases file is malformed");
                    report_failure();
                end
                pkt_queue.push_back(q);
                pkt_blen.push_back(len);
                last_test = test_size.size() - 1;
                test_size[last_test] = test_size[last_test] + 1;
            end else if (tok != "end") begin
                $display("The cases file has an unknown entry %s", tok);
                report_failure();
            end
        end
        $fclose(fd);
    endtask

    // Stable sort per port, high priority first, enqueue order kept
    task automatic build_expected(input int first, input int size);
        int q;
        int len;
        int n;
        for (int p = 0; p < num_ports; p++) begin
            for (int prio = queues_per_port - 1; prio >= 0; prio--) begin
                for (int i = 0; i < size; i++) begin
                    q = pkt_queue[first + i];
                    if (q == p * queues_per_port + prio) begin
                        len = pkt_blen[first + i];
                        n = packet_words(len);
                        for (int w = 0; w < n - 1; w++) begin
                            exp_words.push_back(pack_word(p, q, 0, data_bytes));
                        end
                        exp_words.push_back(pack_word(p, q, 1, len - (n - 1) * data_bytes));
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Note monitor

    task automatic check_note();
        int port;
        int idx;
        int word;
        port = int'(note_queue) / queues_per_port;
        // Words reach the notes 4 cycles after their grant
        if (low_run[port] >= 4) begin
            $display("Port %0d sent a note at time %0t although its ready was low for %0d cycles",
                     port, $time, low_run[port]);
            report_failure();
        end
        idx = -1;
        for (int i = exp_words.size() - 1; i >= 0; i--) begin
            if (exp_words[i][31:24] == port[7:0]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Port %0d sent a note at time %0t with no word left to expect",
                     port, $time);
            report_failure();
        end
        word = exp_words[idx];
        exp_words.delete(idx);
        if (pkt_open[port]) begin
            check_value("note_queue within packet", open_queue[port], note_queue);
        end
        check_value("note_queue", word[23:16], note_queue);
        check_value("note_bytes", word[10:0], note_bytes);
        check_value("note_last", word[12], note_last);
        pkt_open[port] = !note_last;
        open_queue[port] = int'(note_queue);
    endtask

    task automatic track_ready();
        for (int p = 0; p < num_ports; p++) begin
            if (egr_ready[p]) begin
                low_run[p] = 0;
            end else begin
                low_run[p] = low_run[p] + 1;
            end
        end
    endtask

    always @(negedge core_clk_ifc) begin
        if (rst || load_phase) begin
            check_value("note_valid", 0, note_valid);
        end else if (note_valid) begin
            check_note();
        end
        track_ready();
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic toggle_ready();
        int r;
        for (int p = 0; p < num_ports; p++) begin
            r = $random(seed);
            // Flip about one cycle in four
            if (r[1:0] == 2'b00) begin
                ready_now[p] = ~ready_now[p];
            end
        end
    endtask

    task automatic run_test(input int t);
        int first;
        int size;
        first = test_first[t];
        size = test_size[t];
        @(posedge core_clk_ifc);
        load_phase <= 1'b1;
        ready_now = '0;
        egr_ready <= '0;
        for (int i = 0; i < size; i++) begin
            @(posedge core_clk_ifc);
            enq_valid <= 1'b1;
            enq_queue <= queue_log'(pkt_queue[first + i]);
            enq_blen  <= blen_t'(pkt_blen[first + i]);
        end
        @(posedge core_clk_ifc);
        enq_valid <= 1'b0;
        build_expected(first, size);
        // Last enqueue reaches the empty flags
        @(posedge core_clk_ifc);
        load_phase <= 1'b0;
        ready_now = '1;
        if (test_mode[t] != 0) begin
            toggle_ready();
        end
        egr_ready <= ready_now;
        while (exp_words.size() != 0) begin
            @(posedge core_clk_ifc);
            if (test_mode[t] != 0) begin
                toggle_ready();
                egr_ready <= ready_now;
            end
        end
        // Any note in this window has no expected word
        repeat (quiet_cycles) @(posedge core_clk_ifc);
    endtask

    initial begin
        int words;
        rst = 1'b1;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_blen = '0;
        egr_ready = '0;
        ready_now = '0;
        for (int p = 0; p < num_ports; p++) begin
            low_run[p] = 0;
            pkt_open[p] = 1'b0;
            open_queue[p] = 0;
        end
        read_cases();
        words = 0;
        for (int i = 0; i < pkt_blen.size(); i++) begin
            words = words + packet_words(pkt_blen[i]);
        end
        // Word budget plus reset, load and drain windows
        limit_cycles = 4 * words + 200 + 4 + pkt_blen.size()
                     + test_mode.size() * (quiet_cycles + 4);
        repeat (4) @(posedge core_clk_ifc);
        rst <= 1'b0;
        for (int t = 0; t < test_mode.size(); t++) begin
            run_test(t);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge core_clk_ifc);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        report_failure();
    end

endmodule

/* hdl/sched_top.sv */
/* Scheduler top level with length store, port arbiter
   and dequeue engine */

module sched_top #(
    parameter int NUM_PORTS = 4,
    parameter int DATA_BYTES = sched_pkg::bus_data_bytes,
    parameter int QUEUE_DEPTH = 16,
    localparam int queue_log = $clog2(NUM_PORTS) + sched_pkg::queues_per_port_log
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enq_valid,
    input  logic [queue_log-1:0] enq_queue,
    input  sched_pkg::blen_t     enq_blen,
    input  logic [NUM_PORTS-1:0] egr_ready,
    output logic                 note_valid,
    output logic [queue_log-1:0] note_queue,
    output sched_pkg::blen_t     note_bytes,
    output logic                 note_last
);

    import sched_pkg::*;

    localparam int num_queues = NUM_PORTS * queues_per_port;

    logic [num_queues-1:0]            queue_empty;
    logic [num_queues*blen_width-1:0] head_blen;
    logic                             req_valid;
    logic [queue_log-1:0]             req_queue;
    logic                             take_valid;
    logic [queue_log-1:0]             take_queue;
    blen_t                            take_bytes;

    //////////////////////////////////////////////////
    // Packet length FIFOs

    queue_len_store #(
        .NUM_PORTS   (NUM_PORTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) store (
        .clk         (clk),
        .rst         (rst),
        .enq_valid   (enq_valid),
        .enq_queue   (enq_queue),
        .enq_blen    (enq_blen),
        .take_valid  (take_valid),
        .take_queue  (take_queue),
        .take_bytes  (take_bytes),
        .queue_empty (queue_empty),
        .head_blen   (head_blen)
    );

    //////////////////////////////////////////////////
    // Priority and round-robin selection

    port_arbiter #(
        .NUM_PORTS   (NUM_PORTS),
        .DATA_BYTES  (DATA_BYTES)
    ) arbiter (
        .clk         (clk),
        .rst         (rst),
        .queue_empty (queue_empty),
        .head_blen   (head_blen),
        .egr_ready   (egr_ready),
        .note_valid  (note_valid),
        .note_queue  (note_queue),
        .note_last   (note_last),
        .req_valid   (req_valid),
        .req_queue   (req_queue)
    );

    //////////////////////////////////////////////////
    // Word dequeue pipeline

    dequeue_engine #(
        .NUM_PORTS   (NUM_PORTS),
        .DATA_BYTES  (DATA_BYTES)
    ) engine (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_queue   (req_queue),
        .head_blen   (head_blen),
        .take_valid  (take_valid),
        .take_queue  (take_queue),
        .take_bytes  (take_bytes),
        .note_valid  (note_valid),
        .note_queue  (note_queue),
        .note_bytes  (note_bytes),
        .note_last   (note_last)
    );

endmodule

/* hdl/dequeue_engine.sv */
/* Two-stage dequeue pipeline, word size and last flag,
   take strobe to the store and registered notifications */

module dequeue_engine #(
    parameter int NUM_PORTS = 4,
    parameter int DATA_BYTES = 64,
    localparam int num_queues = NUM_PORTS * sched_pkg::queues_per_port,
    localparam int queue_log = $clog2(NUM_PORTS) + sched_pkg::queues_per_port_log
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        req_valid,
    input  logic [queue_log-1:0]                        req_queue,
    input  logic [num_queues*sched_pkg::blen_width-1:0] head_blen,
    output logic                                        take_valid,
    output logic [queue_log-1:0]                        take_queue,
    output sched_pkg::blen_t                            take_bytes,
    output logic                                        note_valid,
    output logic [queue_log-1:0]                        note_queue,
    output sched_pkg::blen_t                            note_bytes,
    output logic                                        note_last
);

    import sched_pkg::*;

    localparam blen_t word_max = blen_t'(DATA_BYTES);

    logic                 s1_valid;
    logic [queue_log-1:0] s1_queue;
    logic                 s2_valid;
    logic [queue_log-1:0] s2_queue;
    blen_t                s2_head;
    blen_t                word_bytes;
    logic                 word_last;

    //////////////////////////////////////////////////
    // Stage 1 and stage 2 registers

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_queue <= req_queue;
        s2_queue <= s1_queue;
    end

    //////////////////////////////////////////////////
    // Stage 2 word sizing

    // Head already reflects takes from earlier words of the packet
    assign s2_head = head_blen[int'(s2_queue)*blen_width +: blen_width];

    assign word_last  = (s2_head <= word_max);
    assign word_bytes = word_last ? s2_head : word_max;

    assign take_valid = s2_valid;
    assign take_queue = s2_queue;
    assign take_bytes = word_bytes;

    //////////////////////////////////////////////////
    // Notification output

    always_ff @(posedge clk) begin
        if (rst) begin
            note_valid <= 1'b0;
        end else begin
            note_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            note_queue <= s2_queue;
            note_bytes <= word_bytes;
            note_last  <= word_last;
        end
    end

    // A zero-byte word means the arbiter asked past the packet end
    a_note_bytes: assert property (@(posedge clk) disable iff (rst)
        note_valid |-> note_bytes != '0);

endmodule

/* hdl/port_arbiter.sv */
/* Per-port strict-priority packet selection and round-robin
   issue of word requests across ready ports */

module port_arbiter #(
    parameter int NUM_PORTS = 4,
    parameter int DATA_BYTES = 64,
    localparam int num_queues = NUM_PORTS * sched_pkg::queues_per_port,
    localparam int queue_log = $clog2(NUM_PORTS) + sched_pkg::queues_per_port_log
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [num_queues-1:0]                       queue_empty,
    input  logic [num_queues*sched_pkg::blen_width-1:0] head_blen,
    input  logic [NUM_PORTS-1:0]                        egr_ready,
    input  logic                                        note_valid,
    input  logic [queue_log-1:0]                        note_queue,
    input  logic                                        note_last,
    output logic                                        req_valid,
    output logic [queue_log-1:0]                        req_queue
);

    import sched_pkg::*;

    localparam int port_log = $clog2(NUM_PORTS);

    sched_state_t         state [NUM_PORTS];
    prio_t                sel_prio [NUM_PORTS];
    blen_t                words_left [NUM_PORTS];
    prio_t                start_prio [NUM_PORTS];
    blen_t                start_head [NUM_PORTS];
    logic [NUM_PORTS-1:0] pending;
    logic [NUM_PORTS-1:0] start_ok;
    logic [NUM_PORTS-1:0] send_ok;
    logic [port_log-1:0]  rr_ptr;
    logic [port_log-1:0]  grant_port;
    logic                 grant_valid;
    logic [port_log-1:0]  note_port;
    logic [port_log-1:0]  req_port;

    assign note_port = note_queue[queue_log-1:queues_per_port_log];
    assign req_port  = req_queue[queue_log-1:queues_per_port_log];

    // Words needed for a packet, rounded up
    function automatic blen_t word_count(input blen_t blen);
        int rounded;
        rounded = int'(blen) + DATA_BYTES - 1;
        return blen_t'(rounded / DATA_BYTES);
    endfunction

    //////////////////////////////////////////////////
    // Strict priority pick per port

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            start_prio[p] = '0;
            pending[p] = 1'b0;
            // Ascending scan, so the highest non-empty priority is kept
            for (int k = 0; k < queues_per_port; k++) begin
                if (!queue_empty[p*queues_per_port + k]) begin
                    start_prio[p] = prio_t'(k);
                    pending[p] = 1'b1;
                end
            end
            start_head[p] =
                head_blen[(p*queues_per_port + int'(start_prio[p]))*blen_width +: blen_width];
            start_ok[p] = (state[p] == IDLE) && egr_ready[p] && pending[p];
            send_ok[p] = (state[p] == SEND) && egr_ready[p];
        end
    end

    //////////////////////////////////////////////////
    // Round robin over ports with words to send

    always_comb begin
        int idx;
        idx = 0;
        grant_valid = 1'b0;
        grant_port = '0;
        // Port after rr_ptr is scanned last, so it wins
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_PORTS;
            if (send_ok[idx]) begin
                grant_valid = 1'b1;
                grant_port = port_log'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            rr_ptr    <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                state[p]      <= IDLE;
                sel_prio[p]   <= '0;
                words_left[p] <= '0;
            end
        end else begin
            req_valid <= grant_valid;
            if (grant_valid) begin
                rr_ptr <= grant_port;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                case (state[p])
                    IDLE: begin
                        if (start_ok[p]) begin
                            state[p]      <= SEND;
                            sel_prio[p]   <= start_prio[p];
                            words_left[p] <= word_count(start_head[p]);
                        end
                    end
                    SEND: begin
                        if (grant_valid && grant_port == port_log'(p)) begin
                            words_left[p] <= words_left[p] - 1'b1;
                            if (words_left[p] == blen_t'(1)) begin
                                state[p] <= WAIT_LAST;
                            end
                        end
                    end
                    WAIT_LAST: begin
                        if (note_valid && note_last && note_port == port_log'(p)) begin
                            state[p] <= IDLE;
                        end
                    end
                    default: state[p] <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            req_queue <= {grant_port, sel_prio[grant_port]};
        end
    end

    //////////////////////////////////////////////////
    // Request checks

    // Ready was high on the cycle the request was picked
    a_req_ready: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> ($past(egr_ready) & (NUM_PORTS'(1) << req_port)) != '0);

    a_req_nonempty: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !queue_empty[req_queue]);

endmodule

/* hdl/queue_len_store.sv */
/* Per-queue circular buffers of packet lengths, head length
   register with decrement and pop, empty flags */

module queue_len_store #(
    parameter int NUM_PORTS = 4,
    parameter int QUEUE_DEPTH = 16,
    localparam int num_queues = NUM_PORTS * sched_pkg::queues_per_port,
    localparam int queue_log = $clog2(NUM_PORTS) + sched_pkg::queues_per_port_log
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        enq_valid,
    input  logic [queue_log-1:0]                        enq_queue,
    input  sched_pkg::blen_t                            enq_blen,
    input  logic                                        take_valid,
    input  logic [queue_log-1:0]                        take_queue,
    input  sched_pkg::blen_t                            take_bytes,
    output logic [num_queues-1:0]                       queue_empty,
    output logic [num_queues*sched_pkg::blen_width-1:0] head_blen
);

    import sched_pkg::*;

    localparam int ptr_log = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cnt_log = $clog2(QUEUE_DEPTH + 1);

    //////////////////////////////////////////////////
    // One FIFO per queue

    for (genvar q = 0; q < num_queues; q++) begin : g_queue
        blen_t              mem [QUEUE_DEPTH];
        logic [ptr_log-1:0] wr_ptr;
        logic [ptr_log-1:0] rd_ptr;
        logic [ptr_log-1:0] wr_next;
        logic [ptr_log-1:0] rd_next;
        logic [cnt_log-1:0] count;
        blen_t              head_rem;
        logic               wr_en;
        logic               tk_en;
        logic               pop;

        assign wr_en = enq_valid && (enq_queue == queue_log'(q));
        assign tk_en = take_valid && (take_queue == queue_log'(q));

        // Last word of the head packet removes the entry
        assign pop = tk_en && (take_bytes == head_rem);

        assign wr_next = (wr_ptr == ptr_log'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        assign rd_next = (rd_ptr == ptr_log'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

        assign queue_empty[q] = (count == '0);
        assign head_blen[q*blen_width +: blen_width] = head_rem;

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_next;
                end
                if (pop) begin
                    rd_ptr <= rd_next;
                end
                if (wr_en && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !wr_en) begin
                    count <= count - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_ptr] <= enq_blen;
            end
        end

        // Remaining bytes of the packet at the head
        always_ff @(posedge clk) begin
            if (pop) begin
                if (count > cnt_log'(1)) begin
                    head_rem <= mem[rd_next];
                end else begin
                    // Last entry leaves, a packet arriving now becomes the head
                    head_rem <= enq_blen;
                end
            end else if (tk_en) begin
                head_rem <= head_rem - take_bytes;
            end else if (wr_en && count == '0) begin
                head_rem <= enq_blen;
            end
        end

        //////////////////////////////////////////////////
        // Checks against the enqueue source and the engine

        a_enq_ok: assert property (@(posedge clk) disable iff (rst)
            wr_en |-> (count != cnt_log'(QUEUE_DEPTH)) && (enq_blen != '0)
                      && (enq_blen <= blen_t'(mtu_bytes)));

        a_take_nonempty: assert property (@(posedge clk) disable iff (rst)
            tk_en |-> count != '0);

        a_take_fits: assert property (@(posedge clk) disable iff (rst)
            tk_en |-> take_bytes <= head_rem);
    end

endmodule

/* hdl/sched_pkg.sv */
/* Shared widths, length type, queue layout constants and
   the per-port scheduler state encoding */

package sched_pkg;

    //////////////////////////////////////////////////
    // Bus and packet sizes

    // Bytes carried by one dequeued bus word
    localparam int bus_data_bytes = 64;

    // Largest packet the queues accept
    localparam int mtu_bytes = 1500;

    // Byte length of a packet or of a single word
    localparam int blen_width = 11;
    typedef logic [blen_width-1:0] blen_t;

    //////////////////////////////////////////////////
    // Queue layout

    // Four strict priorities per egress port
    localparam int queues_per_port_log = 2;
    localparam int queues_per_port = 1 << queues_per_port_log;

    // Priority within a port, higher index wins
    typedef logic [queues_per_port_log-1:0] prio_t;

    //////////////////////////////////////////////////
    // Per-port scheduler FSM

    // IDLE      no packet selected
    // SEND      word requests still to be issued
    // WAIT_LAST all words requested, waiting for the last note
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_LAST
    } sched_state_t;

endpackage
